// File: Makefile
# Verilator build and run of the operand fetch testbench

VERILATOR ?= verilator
TOP       ?= dcache_operand_fetch_tb
FILELIST  ?= dcache_operand_fetch.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dcache_data.hex
// one 64-bit cache word per line, array index 0 to 15 in order
8a3f01d27c45e960
13b7c0de55aa0f21
f00dbabe12345678
0123456789abcdef
fedcba9876543210
5a5a00ff3c3cc3c3
deadbeefcafef00d
7777000011112222
8000000000000001
9e3779b97f4a7c15
a1b2c3d4e5f60718
b00bface0badf00d
c3a5e1f02d4b6978
d1e2f30415263748
e0e1e2e3e4e5e6e7
ffffffff00000000

// File: dcache_operand_fetch.f
rtl/dcache_rd_pkg.sv
rtl/dcache_latency_timer.sv
rtl/dcache_data_array.sv
rtl/dcache_operand_regs.sv
rtl/dcache_rd_fsm.sv
rtl/dcache_operand_fetch.sv
tb/dcache_operand_fetch_tb.sv

// File: rtl/dcache_data_array.sv
// ~~~~~~~~~~~~~~~~~~~~
// data cache model: 16 x 64 word array, request accept,
// fixed latency and a held response
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dcache_data_array (
    input  wire                    clk,
    input  wire                    rst_n,

    // request channel
    input  wire                    rd_req_valid,
    output logic                   rd_req_ready,
    input  dcache_rd_pkg::addr_t   rd_req_address,

    // response channel
    output logic                   rd_dp_valid,
    input  wire                    rd_dp_ready,
    output dcache_rd_pkg::data_t   rd_dp_read_data
);
    import dcache_rd_pkg::*;

    // word storage
    data_t     mem [DCACHE_WORDS];

    word_idx_t req_idx;
    logic      busy;
    logic      req_accept;
    logic      rsp_xfer;
    logic      lat_done;

    initial begin
        $readmemh(DCACHE_INIT_FILE, mem);
    end

    // only bits 6:3 select a word, no tags
    assign req_idx = rd_req_address[WORD_IDX_LSB +: WORD_IDX_W];

    // one read outstanding at a time
    assign rd_req_ready = !busy;
    assign req_accept   = rd_req_valid && rd_req_ready;
    assign rsp_xfer     = rd_dp_valid && rd_dp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (req_accept) begin
            busy <= 1'b1;
        end else if (rsp_xfer) begin
            busy <= 1'b0;
        end
    end

    // word is read at accept and held until it transfers
    always_ff @(posedge clk) begin
        if (req_accept) begin
            rd_dp_read_data <= mem[req_idx];
        end
    end

    // latency restarts on every accepted request
    dcache_latency_timer u_lat_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (req_accept),
        .load_value (lat_cnt_t'(DCACHE_RD_LATENCY)),
        .done       (lat_done)
    );

    // timer stays at zero, so valid holds under back-pressure
    assign rd_dp_valid = busy && lat_done;

endmodule

`default_nettype wire

// File: rtl/dcache_latency_timer.sv
// ~~~~~~~~~~~~~~~~~~~~
// loadable down-counter for the cache read latency
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dcache_latency_timer (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      load,
    input  dcache_rd_pkg::lat_cnt_t  load_value,
    output logic                     done
);
    import dcache_rd_pkg::*;

    lat_cnt_t cnt;

    // the load cycle itself is the first cycle of latency,
    // so the count left behind is one less than the load value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load) begin
            if (load_value == '0) begin
                cnt <= '0;
            end else begin
                cnt <= lat_cnt_t'(load_value - lat_cnt_t'(1));
            end
        end else if (cnt != '0) begin
            // count down and stick at zero
            cnt <= lat_cnt_t'(cnt - lat_cnt_t'(1));
        end
    end

    // level held while idle at zero
    // masked in the load cycle since the old count is stale
    assign done = (cnt == '0) && !load;

endmodule

`default_nettype wire

// File: rtl/dcache_operand_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~
// memory operand fetch top: read FSM, operand registers
// and the data cache model
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dcache_operand_fetch (
    input  wire                    clk,
    input  wire                    rst_n,

    // address stage
    input  wire                    a_valid,
    output logic                   a_ready,
    input  dcache_rd_pkg::addr_t   op0_address,
    input  wire                    op0_address_is_valid,
    input  dcache_rd_pkg::addr_t   op1_address,
    input  wire                    op1_address_is_valid,

    // execute stage
    input  wire                    e_ready,
    output logic                   e_valid,
    output dcache_rd_pkg::data_t   op0_data,
    output dcache_rd_pkg::data_t   op1_data
);
    import dcache_rd_pkg::*;

    // cache request / response
    logic   rd_req_valid;
    logic   rd_req_ready;
    addr_t  rd_req_address;
    logic   rd_dp_valid;
    logic   rd_dp_ready;
    data_t  rd_dp_read_data;

    // operand register control
    opsel_t opsel;
    logic   ld_op0;
    logic   ld_op1;
    logic   clr_ops;

    dcache_rd_fsm u_rd_fsm (
        .clk                  (clk),
        .rst_n                (rst_n),
        .a_valid              (a_valid),
        .e_ready              (e_ready),
        .op0_address_is_valid (op0_address_is_valid),
        .op1_address_is_valid (op1_address_is_valid),
        .a_ready              (a_ready),
        .e_valid              (e_valid),
        .rd_req_valid         (rd_req_valid),
        .rd_req_ready         (rd_req_ready),
        .rd_dp_valid          (rd_dp_valid),
        .rd_dp_ready          (rd_dp_ready),
        .opsel                (opsel),
        .ld_op0               (ld_op0),
        .ld_op1               (ld_op1),
        .clr_ops              (clr_ops)
    );

    dcache_operand_regs u_operand_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .op0_address     (op0_address),
        .op1_address     (op1_address),
        .opsel           (opsel),
        .ld_op0          (ld_op0),
        .ld_op1          (ld_op1),
        .clr_ops         (clr_ops),
        .rd_dp_read_data (rd_dp_read_data),
        .rd_req_address  (rd_req_address),
        .op0_data        (op0_data),
        .op1_data        (op1_data)
    );

    // cache model answering the fetch
    dcache_data_array u_data_array (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd_req_valid    (rd_req_valid),
        .rd_req_ready    (rd_req_ready),
        .rd_req_address  (rd_req_address),
        .rd_dp_valid     (rd_dp_valid),
        .rd_dp_ready     (rd_dp_ready),
        .rd_dp_read_data (rd_dp_read_data)
    );

endmodule

`default_nettype wire

// File: rtl/dcache_operand_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// request address mux and the two operand data registers
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dcache_operand_regs (
    input  wire                    clk,
    input  wire                    rst_n,

    // operand addresses from the address stage
    input  dcache_rd_pkg::addr_t   op0_address,
    input  dcache_rd_pkg::addr_t   op1_address,

    // control from the FSM
    input  dcache_rd_pkg::opsel_t  opsel,
    input  wire                    ld_op0,
    input  wire                    ld_op1,
    input  wire                    clr_ops,

    // cache side
    input  dcache_rd_pkg::data_t   rd_dp_read_data,
    output dcache_rd_pkg::addr_t   rd_req_address,

    // operands to execute
    output dcache_rd_pkg::data_t   op0_data,
    output dcache_rd_pkg::data_t   op1_data
);
    import dcache_rd_pkg::*;

    // request address select
    assign rd_req_address = (opsel == OPSEL_OP1) ? op1_address : op0_address;

    // operand registers
    // cleared at start so an unused operand reads as zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op0_data <= '0;
            op1_data <= '0;
        end else if (clr_ops) begin
            op0_data <= '0;
            op1_data <= '0;
        end else begin
            if (ld_op0) begin
                op0_data <= rd_dp_read_data;
            end
            if (ld_op1) begin
                op1_data <= rd_dp_read_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/dcache_rd_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~
// operand read FSM: sequences op0 then op1 reads,
// drives cache handshakes and the execute strobe
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dcache_rd_fsm (
    input  wire                    clk,
    input  wire                    rst_n,

    // address stage / execute stage
    input  wire                    a_valid,
    input  wire                    e_ready,
    input  wire                    op0_address_is_valid,
    input  wire                    op1_address_is_valid,
    output logic                   a_ready,
    output logic                   e_valid,

    // cache handshakes
    output logic                   rd_req_valid,
    input  wire                    rd_req_ready,
    input  wire                    rd_dp_valid,
    output logic                   rd_dp_ready,

    // operand register control
    output dcache_rd_pkg::opsel_t  opsel,
    output logic                   ld_op0,
    output logic                   ld_op1,
    output logic                   clr_ops
);
    import dcache_rd_pkg::*;

    rd_state_t state;
    rd_state_t state_nxt;

    // op1 still to fetch after op0
    logic      op1_needed;
    logic      start;

    // start only with both stages ready and some operand to read
    assign start = a_valid && e_ready &&
                   (op0_address_is_valid || op1_address_is_valid);

    // next state
    always_comb begin
        state_nxt = state;
        unique case (state)
            ST_IDLE: begin
                if (start) begin
                    // op0 need is used here, op1 need is latched
                    state_nxt = op0_address_is_valid ? ST_REQ0 : ST_REQ1;
                end
            end
            ST_REQ0: begin
                if (rd_req_ready) begin
                    state_nxt = ST_WAIT0;
                end
            end
            ST_WAIT0: begin
                if (rd_dp_valid) begin
                    state_nxt = op1_needed ? ST_REQ1 : ST_DONE;
                end
            end
            ST_REQ1: begin
                if (rd_req_ready) begin
                    state_nxt = ST_WAIT1;
                end
            end
            ST_WAIT1: begin
                if (rd_dp_valid) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                // one-cycle hand-off to execute
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            op1_needed <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE && start) begin
                op1_needed <= op1_address_is_valid;
            end
        end
    end

    // state decoded outputs
    assign clr_ops      = (state == ST_IDLE) && start;
    assign rd_req_valid = (state == ST_REQ0) || (state == ST_REQ1);
    assign rd_dp_ready  = (state == ST_WAIT0) || (state == ST_WAIT1);
    // address mux follows the request in flight
    assign opsel        = (state == ST_REQ1 || state == ST_WAIT1) ? OPSEL_OP1 : OPSEL_OP0;

    // capture on response transfer
    assign ld_op0 = (state == ST_WAIT0) && rd_dp_valid;
    assign ld_op1 = (state == ST_WAIT1) && rd_dp_valid;

    // release address stage together with the execute strobe
    assign e_valid = (state == ST_DONE);
    assign a_ready = (state == ST_DONE);

endmodule

`default_nettype wire

// File: rtl/dcache_rd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared widths, vector types, cache model constants
// and the read sequencer state encoding
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dcache_rd_pkg;

    // basic widths
    localparam int ADDR_W       = 32;
    localparam int DATA_W       = 64;
    localparam int WORD_IDX_W   = 4;
    localparam int LAT_CNT_W    = 3;

    // word index sits above the byte offset of a 64-bit word
    localparam int WORD_IDX_LSB = 3;

    // cache model geometry and timing
    localparam int DCACHE_WORDS      = 16;
    localparam int DCACHE_RD_LATENCY = 3;
    localparam string DCACHE_INIT_FILE = "dcache_data.hex";

    // operand byte address
    typedef logic [ADDR_W-1:0]     addr_t;
    // one cache word, also one operand value
    typedef logic [DATA_W-1:0]     data_t;
    // array index from address bits 6:3
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    // read latency count
    typedef logic [LAT_CNT_W-1:0]  lat_cnt_t;
    // which operand the request is for
    typedef logic                  opsel_t;

    localparam opsel_t OPSEL_OP0 = 1'b0;
    localparam opsel_t OPSEL_OP1 = 1'b1;

    // read sequencer states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_REQ0  = 3'd1,
        ST_WAIT0 = 3'd2,
        ST_REQ1  = 3'd3,
        ST_WAIT1 = 3'd4,
        ST_DONE  = 3'd5
    } rd_state_t;

endpackage

`default_nettype wire

// File: tb/dcache_operand_fetch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// operand fetch testbench with clock, reset,
// fetch table of expected words and cycles, compare tasks
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module dcache_operand_fetch_tb;
    import dcache_rd_pkg::*;

    localparam int WAIT_LIMIT  = 40;
    localparam int IDLE_CYCLES = 20;
    localparam int HOLD_CYCLES = 3;
    localparam int RANDOM_ROWS = 8;

    // one fetch with its stimulus and the expected answer
    typedef struct packed {
        logic       a_valid;
        logic       e_ready;
        logic       v0;
        logic       v1;
        addr_t      addr0;
        addr_t      addr1;
        logic       exp_start;
        data_t      exp_op0;
        data_t      exp_op1;
        logic [7:0] exp_cycle;
    } row_t;

    logic  clk;
    logic  rst_n;
    logic  a_valid;
    logic  e_ready;
    addr_t op0_address;
    addr_t op1_address;
    logic  op0_address_is_valid;
    logic  op1_address_is_valid;
    logic  a_ready;
    logic  e_valid;
    data_t op0_data;
    data_t op1_data;

    // expected contents of the cache array
    data_t ref_words [DCACHE_WORDS];
    row_t  rows [$];
    // operand values the registers should hold between fetches
    data_t held_op0;
    data_t held_op1;

    dcache_operand_fetch uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .a_valid              (a_valid),
        .a_ready              (a_ready),
        .op0_address          (op0_address),
        .op0_address_is_valid (op0_address_is_valid),
        .op1_address          (op1_address),
        .op1_address_is_valid (op1_address_is_valid),
        .e_ready              (e_ready),
        .e_valid              (e_valid),
        .op0_data             (op0_data),
        .op1_data             (op1_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_ref_words();
        ref_words[0]  = 64'h8a3f01d27c45e960;
        ref_words[1]  = 64'h13b7c0de55aa0f21;
        ref_words[2]  = 64'hf00dbabe12345678;
        ref_words[3]  = 64'h0123456789abcdef;
        ref_words[4]  = 64'hfedcba9876543210;
        ref_words[5]  = 64'h5a5a00ff3c3cc3c3;
        ref_words[6]  = 64'hdeadbeefcafef00d;
        ref_words[7]  = 64'h7777000011112222;
        ref_words[8]  = 64'h8000000000000001;
        ref_words[9]  = 64'h9e3779b97f4a7c15;
        ref_words[10] = 64'ha1b2c3d4e5f60718;
        ref_words[11] = 64'hb00bface0badf00d;
        ref_words[12] = 64'hc3a5e1f02d4b6978;
        ref_words[13] = 64'hd1e2f30415263748;
        ref_words[14] = 64'he0e1e2e3e4e5e6e7;
        ref_words[15] = 64'hffffffff00000000;
    endtask

    // word select uses address bits 6:3 only
    function automatic word_idx_t word_index(input addr_t a);
        return a[6:3];
    endfunction

    task automatic add_row(input logic av, input logic er, input logic v0, input logic v1,
                           input addr_t a0, input addr_t a1);
        row_t r;
        int   n;
        r = '0;
        r.a_valid   = av;
        r.e_ready   = er;
        r.v0        = v0;
        r.v1        = v1;
        r.addr0     = a0;
        r.addr1     = a1;
        r.exp_start = av && er && (v0 || v1);
        if (r.exp_start) begin
            n = int'(v0) + int'(v1);
            // unused operand is cleared at start
            r.exp_op0   = v0 ? ref_words[word_index(a0)] : '0;
            r.exp_op1   = v1 ? ref_words[word_index(a1)] : '0;
            r.exp_cycle = 8'(1 + n * (DCACHE_RD_LATENCY + 1));
            held_op0    = r.exp_op0;
            held_op1    = r.exp_op1;
        end else begin
            r.exp_op0 = held_op0;
            r.exp_op1 = held_op1;
        end
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        a_valid              = r.a_valid;
        e_ready              = r.e_ready;
        op0_address_is_valid = r.v0;
        op1_address_is_valid = r.v1;
        op0_address          = r.addr0;
        op1_address          = r.addr1;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // fetch that should start and its cycle count up to e_valid
    task automatic run_fetch(input row_t r, input int idx);
        int   cyc;
        logic seen;
        cyc  = 0;
        seen = 1'b0;
        drive_row(r);
        while (!seen && cyc < WAIT_LIMIT) begin
            next_cycle();
            cyc = cyc + 1;
            if (cyc == 1) begin
                a_valid = 1'b0;
            end
            if (e_valid === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_bit("a_ready", a_ready, 1'b0);
            end
        end
        if (!seen) begin
            $display("timeout: e_valid never rose for table row %0d", idx);
            abort_run();
        end
        check_cycle("e_valid cycle", cyc, int'(r.exp_cycle));
        check_bit("a_ready", a_ready, 1'b1);
        check_data("op0_data", op0_data, r.exp_op0);
        check_data("op1_data", op1_data, r.exp_op1);
        // new addresses must not disturb the held operands
        op0_address = addr_t'($urandom());
        op1_address = addr_t'($urandom());
        for (int k = 0; k < HOLD_CYCLES; k++) begin
            next_cycle();
            check_bit("e_valid", e_valid, 1'b0);
            check_bit("a_ready", a_ready, 1'b0);
            check_data("op0_data", op0_data, r.exp_op0);
            check_data("op1_data", op1_data, r.exp_op1);
        end
    endtask

    // no start expected so outputs stay quiet and held
    task automatic run_idle(input row_t r);
        drive_row(r);
        for (int k = 0; k < IDLE_CYCLES; k++) begin
            next_cycle();
            check_bit("e_valid", e_valid, 1'b0);
            check_bit("a_ready", a_ready, 1'b0);
            check_data("op0_data", op0_data, r.exp_op0);
            check_data("op1_data", op1_data, r.exp_op1);
        end
        a_valid = 1'b0;
        e_ready = 1'b0;
    endtask

    initial begin
        logic [1:0] rv;
        rst_n                = 1'b0;
        a_valid              = 1'b0;
        e_ready              = 1'b0;
        op0_address_is_valid = 1'b0;
        op1_address_is_valid = 1'b0;
        op0_address          = '0;
        op1_address          = '0;
        held_op0             = '0;
        held_op1             = '0;
        void'($urandom(32'h19f5));
        load_ref_words();

        // two operands and then each alone
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 32'h0000_0008, 32'h0000_0030);
        add_row(1'b1, 1'b1, 1'b1, 1'b0, 32'h0000_0018, 32'h0000_0050);
        add_row(1'b1, 1'b1, 1'b0, 1'b1, 32'h0000_0060, 32'h0000_0078);
        // no start cases
        add_row(1'b1, 1'b0, 1'b1, 1'b1, 32'h0000_0010, 32'h0000_0020);
        add_row(1'b0, 1'b1, 1'b1, 1'b1, 32'h0000_0010, 32'h0000_0020);
        add_row(1'b1, 1'b1, 1'b0, 1'b0, 32'h0000_0010, 32'h0000_0020);
        // back to back with same and then different addresses
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 32'h0000_0008, 32'h0000_0030);
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 32'h0000_0008, 32'h0000_0030);
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 32'h0000_0020, 32'h0000_0048);
        // same words as row 0 with other address bits changed
        add_row(1'b1, 1'b1, 1'b1, 1'b1, 32'hffff_ff8f, 32'h1234_56b5);
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            rv = 2'($urandom());
            add_row(1'b1, 1'b1, rv[0], rv[1], addr_t'($urandom()), addr_t'($urandom()));
        end

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // quiet after reset and before any start
        for (int i = 0; i < 4; i++) begin
            check_bit("e_valid", e_valid, 1'b0);
            check_bit("a_ready", a_ready, 1'b0);
            check_data("op0_data", op0_data, '0);
            check_data("op1_data", op1_data, '0);
            next_cycle();
        end

        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].exp_start) begin
                run_fetch(rows[i], i);
            end else begin
                run_idle(rows[i]);
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
